// File: sources.f
hw/dcache_pkg.sv
hw/cache_way.sv
hw/victim_tree.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/wb_buffer.sv
hw/mem_arbiter.sv
hw/main_mem.sv
hw/dcache_top.sv
verif/dcache_assertions.sv
verif/dcache_tb.sv

// File: verif/dcache_tb.sv
// directed and random testbench for the data cache top; run with the file list in sources.f
`timescale 1ns/10ps

module dcache_tb;

  logic                             clock = 1'b0;
  logic                             reset;
  logic                             cpu_req;
  dcache_pkg::cpu_req_t             cpu_cmd;
  logic                             cpu_ready;
  logic                             cpu_done;
  logic                             cpu_hit;
  logic [dcache_pkg::data_bits-1:0] cpu_rdata;

  // reference memory and per-set model of tags and fill order
  logic [dcache_pkg::data_bits-1:0] ref_mem [2**(dcache_pkg::tag_bits+dcache_pkg::idx_bits)];
  logic                             line_valid [dcache_pkg::num_idx][dcache_pkg::num_way];
  logic [dcache_pkg::tag_bits-1:0]  line_tag [dcache_pkg::num_idx][dcache_pkg::num_way];
  int                               fill_count [dcache_pkg::num_idx];
  int                               fill_order [dcache_pkg::num_way] = '{0, 2, 1, 3};

  dcache_top dcache_top_i (
    .clock     (clock),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .cpu_cmd   (cpu_cmd),
    .cpu_ready (cpu_ready),
    .cpu_done  (cpu_done),
    .cpu_hit   (cpu_hit),
    .cpu_rdata (cpu_rdata)
  );

  always #10 clock = ~clock;

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // bound protocol checks count their own failures
  always @(posedge clock) begin
    assert (dcache_top_i.chk_i.error_count == 0) else begin
      $display("a bound protocol assertion on the cache top failed at %0t", $time);
      stop_run();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic predict_hit(input logic [4:0] tag, input logic [2:0] set_index);
    logic found;
    found = 1'b0;
    for (int w = 0; w < dcache_pkg::num_way; w++) begin
      if (line_valid[set_index][w] && (line_tag[set_index][w] == tag)) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // every miss fills, the way follows 0, 2, 1, 3 per set
  function automatic void record_fill(input logic [4:0] tag, input logic [2:0] set_index);
    int w;
    w = fill_order[fill_count[set_index] % dcache_pkg::num_way];
    line_valid[set_index][w] = 1'b1;
    line_tag[set_index][w] = tag;
    fill_count[set_index]++;
  endfunction

  // one request, checked against the model; returns hit and cycles from sampling edge to done
  task automatic access(input logic store, input logic [4:0] tag, input logic [2:0] set_index,
                        input logic [2:0] offset, input logic [63:0] data,
                        output logic hit, output int cycles);
    logic [7:0]  word;
    logic        exp_hit;
    logic [63:0] exp_data;
    int          n;
    word = {tag, set_index};
    exp_hit = predict_hit(tag, set_index);
    exp_data = ref_mem[word];
    @(posedge clock);
    #1;
    n = 0;
    while (!cpu_ready) begin
      if (n == 100) begin
        $display("timeout: cpu_ready stayed low for 100 cycles at %0t", $time);
        stop_run();
      end
      @(posedge clock);
      #1;
      n++;
    end
    cpu_cmd.store = store;
    cpu_cmd.addr.tag = tag;
    cpu_cmd.addr.set_index = set_index;
    cpu_cmd.addr.ignore = offset;
    cpu_cmd.data = data;
    cpu_req = 1'b1;
    @(posedge clock);
    #1;
    cpu_req = 1'b0;
    cycles = 0;
    while (!cpu_done) begin
      if (cycles == 100) begin
        $display("timeout: no cpu_done within 100 cycles at %0t", $time);
        stop_run();
      end
      @(posedge clock);
      #1;
      cycles++;
    end
    hit = cpu_hit;
    assert (cpu_hit === exp_hit) else begin
      $display("Error at %0t: cpu_hit = %b, expected %b", $time, cpu_hit, exp_hit);
      stop_run();
    end
    if (!store) begin
      assert (cpu_rdata === exp_data) else begin
        $display("Error at %0t: cpu_rdata = %h, expected %h", $time, cpu_rdata, exp_data);
        stop_run();
      end
    end
    if (store) begin
      ref_mem[word] = data;
    end
    if (!exp_hit) begin
      record_fill(tag, set_index);
    end
  endtask

  task automatic reset_state();
    logic hit;
    int   cycles;
    assert (cpu_ready === 1'b1 && cpu_done === 1'b0) else begin
      $display("Error at %0t: cpu_ready = %b, cpu_done = %b, expected 1 and 0",
               $time, cpu_ready, cpu_done);
      stop_run();
    end
    access(1'b0, 5'd7, 3'd2, 3'd0, '0, hit, cycles);
    assert (cycles >= 4) else begin
      $display("Error at %0t: load miss cycles = %0d, expected at least 4", $time, cycles);
      stop_run();
    end
  endtask

  task automatic store_then_load();
    logic hit;
    int   cycles;
    access(1'b1, 5'd2, 3'd1, 3'd0, 64'h0123_4567_89ab_cdef, hit, cycles);
    access(1'b0, 5'd2, 3'd1, 3'd5, '0, hit, cycles);
    assert (hit === 1'b1 && cycles == 1) else begin
      $display("Error at %0t: load hit cycles = %0d, expected 1", $time, cycles);
      stop_run();
    end
  endtask

  // five tags into set 3, the fifth fill replaces way0
  task automatic victim_order();
    logic hit;
    int   cycles;
    for (int t = 1; t <= 5; t++) begin
      access(1'b1, 5'(t), 3'd3, 3'd0, 64'hc0de_0000_0000_0300 | 64'(t), hit, cycles);
      if (t <= 4) begin
        assert (cycles == 2) else begin
          $display("Error at %0t: store miss cycles = %0d, expected 2", $time, cycles);
          stop_run();
        end
      end
    end
    for (int t = 2; t <= 4; t++) begin
      access(1'b0, 5'(t), 3'd3, 3'd0, '0, hit, cycles);
      assert (hit === 1'b1) else begin
        $display("Error at %0t: cpu_hit = %b for tag %0d, expected 1", $time, hit, t);
        stop_run();
      end
    end
    // evicted dirty word must come back from memory
    access(1'b0, 5'd1, 3'd3, 3'd0, '0, hit, cycles);
    assert (hit === 1'b0) else begin
      $display("Error at %0t: cpu_hit = %b for evicted tag, expected 0", $time, hit);
      stop_run();
    end
  endtask

  task automatic buffer_backpressure();
    logic hit;
    int   cycles;
    for (int t = 0; t < 8; t++) begin
      for (int s = 4; s < 8; s++) begin
        access(1'b1, 5'(t + 8), 3'(s), 3'd0, {32'(t), 32'(s)} ^ 64'h5a5a_5a5a_0000_0000,
               hit, cycles);
      end
    end
    for (int t = 0; t < 8; t++) begin
      for (int s = 4; s < 8; s++) begin
        access(1'b0, 5'(t + 8), 3'(s), 3'd0, '0, hit, cycles);
      end
    end
  endtask

  task automatic random_traffic();
    logic [31:0] rng;
    logic [31:0] rnd_data;
    logic        hit;
    int          cycles;
    rng = 32'd11;
    for (int i = 0; i < 200; i++) begin
      rng = xorshift32(rng);
      rnd_data = xorshift32(rng);
      access(rng[0], {2'b00, rng[5:3]}, {1'b0, rng[2:1]}, rng[8:6], {rnd_data, ~rng},
             hit, cycles);
      rng = rnd_data;
    end
  endtask

  initial begin
    cpu_req = 1'b0;
    cpu_cmd = '0;
    reset = 1'b1;
    for (int i = 0; i < 2**(dcache_pkg::tag_bits+dcache_pkg::idx_bits); i++) begin
      ref_mem[i] = '0;
    end
    for (int s = 0; s < dcache_pkg::num_idx; s++) begin
      fill_count[s] = 0;
      for (int w = 0; w < dcache_pkg::num_way; w++) begin
        line_valid[s][w] = 1'b0;
        line_tag[s][w] = '0;
      end
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    reset_state();
    store_then_load();
    victim_order();
    buffer_backpressure();
    random_traffic();
    if (dcache_top_i.chk_i.error_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

// File: verif/dcache_assertions.sv
// protocol checks for the cache top; attached to dcache_top with the bind at the end
`timescale 1ns/10ps

module dcache_assertions (
  input logic clock,
  input logic reset,
  input logic cpu_req,
  input logic cpu_ready,
  input logic cpu_done,
  input logic wb_ack,
  input logic refill_ack,
  input logic mem_valid,
  input logic mem_ack
);

  int error_count = 0;

  req_when_ready: assert property (@(posedge clock) disable iff (reset) cpu_req |-> cpu_ready)
    else begin
      $error("cpu_req raised while cpu_ready is low");
      error_count++;
    end

  // done is a single pulse and the port reopens right after it
  ready_after_done: assert property (@(posedge clock) disable iff (reset)
                                     cpu_done |=> cpu_ready && !cpu_done)
    else begin
      $error("cpu_ready not high or cpu_done still high after cpu_done");
      error_count++;
    end

  // every memory ack goes back to exactly one requester
  single_ack: assert property (@(posedge clock) disable iff (reset)
                               mem_ack |-> (wb_ack != refill_ack))
    else begin
      $error("mem_ack not routed to exactly one of wb_ack and refill_ack");
      error_count++;
    end

  // grant stays locked while the request is in flight
  ack_after_valid: assert property (@(posedge clock) disable iff (reset)
                                    mem_valid |=> mem_ack && !mem_valid)
    else begin
      $error("mem_ack missing or new mem_valid one cycle after mem_valid");
      error_count++;
    end

endmodule

bind dcache_top dcache_assertions chk_i (
  .clock      (clock),
  .reset      (reset),
  .cpu_req    (cpu_req),
  .cpu_ready  (cpu_ready),
  .cpu_done   (cpu_done),
  .wb_ack     (wb_ack),
  .refill_ack (refill_ack),
  .mem_valid  (mem_valid),
  .mem_ack    (mem_ack)
);

// File: hw/dcache_top.sv
// data cache subsystem top; ties controller, array, write-back buffer, arbiter and memory
`timescale 1ns/10ps

module dcache_top (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               cpu_req,
  input  dcache_pkg::cpu_req_t               cpu_cmd,
  output logic                               cpu_ready,
  output logic                               cpu_done,
  output logic                               cpu_hit,
  output logic [dcache_pkg::data_bits-1:0]   cpu_rdata
);

  logic                             hit;
  logic [dcache_pkg::data_bits-1:0] hit_data;
  dcache_pkg::cache_line_t          victim;
  dcache_pkg::sass_addr_t           victim_addr;
  dcache_pkg::sass_addr_t           array_addr;
  logic                             fill_en;
  dcache_pkg::cache_line_t          fill_line;
  logic                             use_hit_way;
  logic                             wb_push;
  dcache_pkg::mem_req_t             wb_entry;
  logic                             wb_full;
  logic                             wb_mreq;
  dcache_pkg::mem_req_t             wb_head;
  logic                             wb_ack;
  logic                             refill_mreq;
  dcache_pkg::mem_req_t             refill_req;
  logic                             refill_ack;
  logic [dcache_pkg::data_bits-1:0] refill_rdata;
  logic                             mem_valid;
  dcache_pkg::mem_req_t             mem_cmd;
  logic                             mem_ack;
  logic [dcache_pkg::data_bits-1:0] mem_rdata;

  dcache_ctrl ctrl_i (
    .clock        (clock),
    .reset        (reset),
    .cpu_req      (cpu_req),
    .cpu_cmd      (cpu_cmd),
    .hit          (hit),
    .hit_data     (hit_data),
    .victim       (victim),
    .victim_addr  (victim_addr),
    .wb_full      (wb_full),
    .refill_ack   (refill_ack),
    .refill_rdata (refill_rdata),
    .cpu_ready    (cpu_ready),
    .cpu_done     (cpu_done),
    .cpu_hit      (cpu_hit),
    .cpu_rdata    (cpu_rdata),
    .array_addr   (array_addr),
    .fill_en      (fill_en),
    .fill_line    (fill_line),
    .use_hit_way  (use_hit_way),
    .wb_push      (wb_push),
    .wb_entry     (wb_entry),
    .refill_mreq  (refill_mreq),
    .refill_req   (refill_req)
  );

  dcache_array array_i (
    .clock       (clock),
    .reset       (reset),
    .addr        (array_addr),
    .fill_en     (fill_en),
    .fill_line   (fill_line),
    .use_hit_way (use_hit_way),
    .hit         (hit),
    .hit_data    (hit_data),
    .victim      (victim),
    .victim_addr (victim_addr)
  );

  wb_buffer wb_i (
    .clock (clock),
    .reset (reset),
    .push  (wb_push),
    .entry (wb_entry),
    .ack   (wb_ack),
    .full  (wb_full),
    .mreq  (wb_mreq),
    .head  (wb_head)
  );

  mem_arbiter arb_i (
    .clock        (clock),
    .reset        (reset),
    .wb_mreq      (wb_mreq),
    .wb_req       (wb_head),
    .refill_mreq  (refill_mreq),
    .refill_req   (refill_req),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .mem_valid    (mem_valid),
    .mem_cmd      (mem_cmd),
    .wb_ack       (wb_ack),
    .refill_ack   (refill_ack),
    .refill_rdata (refill_rdata)
  );

  main_mem mem_i (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

// File: hw/main_mem.sv
// 256-word backing store behind the cache; one request at a time, acknowledged next cycle
`timescale 1ns/10ps

module main_mem (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               mem_valid,
  input  dcache_pkg::mem_req_t               mem_cmd,
  output logic                               mem_ack,
  output logic [dcache_pkg::data_bits-1:0]   mem_rdata
);

  logic [dcache_pkg::data_bits-1:0] words [2**(dcache_pkg::tag_bits+dcache_pkg::idx_bits)];
  logic [dcache_pkg::tag_bits+dcache_pkg::idx_bits-1:0] word_addr;

  // byte offset dropped
  assign word_addr = {mem_cmd.addr.tag, mem_cmd.addr.set_index};

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_ack <= 1'b0;
      for (int i = 0; i < 2**(dcache_pkg::tag_bits+dcache_pkg::idx_bits); i++) begin
        words[i] <= '0;
      end
    end else begin
      mem_ack <= mem_valid;
      if (mem_valid && mem_cmd.write) begin
        words[word_addr] <= mem_cmd.data;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid && !mem_cmd.write) begin
      mem_rdata <= words[word_addr];
    end
  end

endmodule

// File: hw/mem_arbiter.sv
// shares the memory port between write-back buffer and refill path, write-back first
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               wb_mreq,
  input  dcache_pkg::mem_req_t               wb_req,
  input  logic                               refill_mreq,
  input  dcache_pkg::mem_req_t               refill_req,
  input  logic                               mem_ack,
  input  logic [dcache_pkg::data_bits-1:0]   mem_rdata,
  output logic                               mem_valid,
  output dcache_pkg::mem_req_t               mem_cmd,
  output logic                               wb_ack,
  output logic                               refill_ack,
  output logic [dcache_pkg::data_bits-1:0]   refill_rdata
);

  typedef enum logic [1:0] {own_none, own_wb, own_refill} owner_t;

  owner_t owner;
  logic   pick_wb;

  // while free the buffer wins, once issued the owner keeps the port
  assign pick_wb   = (owner == own_none) ? wb_mreq : (owner == own_wb);
  assign mem_valid = (owner == own_none) && (wb_mreq || refill_mreq);
  assign mem_cmd   = pick_wb ? wb_req : refill_req;

  assign wb_ack       = mem_ack && (owner == own_wb);
  assign refill_ack   = mem_ack && (owner == own_refill);
  assign refill_rdata = mem_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner <= own_none;
    end else if (mem_valid) begin
      owner <= pick_wb ? own_wb : own_refill;
    end else if (mem_ack) begin
      owner <= own_none;
    end
  end

endmodule

// File: hw/wb_buffer.sv
// two-entry FIFO of dirty victims; the head entry is offered to memory until acknowledged
`timescale 1ns/10ps

module wb_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    push,
  input  dcache_pkg::mem_req_t    entry,
  input  logic                    ack,
  output logic                    full,
  output logic                    mreq,
  output dcache_pkg::mem_req_t    head
);

  dcache_pkg::mem_req_t                        slots [dcache_pkg::wb_depth];
  logic [$clog2(dcache_pkg::wb_depth+1)-1:0]   count;
  logic [$clog2(dcache_pkg::wb_depth)-1:0]     rd_ptr;
  logic [$clog2(dcache_pkg::wb_depth)-1:0]     wr_ptr;

  // two slots, so the tail is just past the head
  assign wr_ptr = rd_ptr + count[$clog2(dcache_pkg::wb_depth)-1:0];

  assign full = (count == dcache_pkg::wb_depth);
  assign mreq = (count != '0);
  assign head = slots[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      count  <= '0;
      rd_ptr <= '0;
    end else begin
      if (ack) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, ack})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      slots[wr_ptr] <= entry;
    end
  end

endmodule

// File: hw/dcache_ctrl.sv
// processor-side FSM of the data cache; runs hits, evictions, refills and store installs
`timescale 1ns/10ps

module dcache_ctrl (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               cpu_req,
  input  dcache_pkg::cpu_req_t               cpu_cmd,
  input  logic                               hit,
  input  logic [dcache_pkg::data_bits-1:0]   hit_data,
  input  dcache_pkg::cache_line_t            victim,
  input  dcache_pkg::sass_addr_t             victim_addr,
  input  logic                               wb_full,
  input  logic                               refill_ack,
  input  logic [dcache_pkg::data_bits-1:0]   refill_rdata,
  output logic                               cpu_ready,
  output logic                               cpu_done,
  output logic                               cpu_hit,
  output logic [dcache_pkg::data_bits-1:0]   cpu_rdata,
  output dcache_pkg::sass_addr_t             array_addr,
  output logic                               fill_en,
  output dcache_pkg::cache_line_t            fill_line,
  output logic                               use_hit_way,
  output logic                               wb_push,
  output dcache_pkg::mem_req_t               wb_entry,
  output logic                               refill_mreq,
  output dcache_pkg::mem_req_t               refill_req
);

  typedef enum logic [2:0] {st_idle, st_lookup, st_evict, st_refill, st_done} state_t;

  state_t               state;
  state_t               state_nxt;
  dcache_pkg::cpu_req_t req_q;
  logic                 need_push;
  logic                 evict_go;

  // a dirty victim has to get into the buffer before its way is reused
  assign need_push = victim.valid && victim.dirty;
  assign evict_go  = !(need_push && wb_full);

  assign cpu_ready   = (state == st_idle);
  assign cpu_done    = (state == st_done);
  assign array_addr  = req_q.addr;
  assign use_hit_way = (state == st_lookup);
  assign wb_push     = (state == st_evict) && need_push && !wb_full;
  assign refill_mreq = (state == st_refill);

  always_comb begin
    case (state)
      st_lookup: fill_en = hit && req_q.store;
      st_evict:  fill_en = evict_go && req_q.store;
      st_refill: fill_en = refill_ack;
      default:   fill_en = 1'b0;
    endcase
  end

  // stores install dirty, refills clean
  always_comb begin
    fill_line.valid  = 1'b1;
    fill_line.dirty  = req_q.store;
    fill_line.tag    = req_q.addr.tag;
    fill_line.data   = req_q.store ? req_q.data : refill_rdata;
    wb_entry.write   = 1'b1;
    wb_entry.addr    = victim_addr;
    wb_entry.data    = victim.data;
    refill_req.write = 1'b0;
    refill_req.addr  = req_q.addr;
    refill_req.data  = '0;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:   if (cpu_req) state_nxt = st_lookup;
      st_lookup: state_nxt = hit ? st_done : st_evict;
      st_evict:  if (evict_go) state_nxt = req_q.store ? st_done : st_refill;
      st_refill: if (refill_ack) state_nxt = st_done;
      default:   state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // request and response payload
  always_ff @(posedge clock) begin
    if (cpu_ready && cpu_req) begin
      req_q <= cpu_cmd;
    end
    if (state == st_lookup) begin
      cpu_hit   <= hit;
      cpu_rdata <= hit_data;
    end
    if ((state == st_refill) && refill_ack) begin
      cpu_rdata <= refill_rdata;
    end
  end

endmodule

// File: hw/dcache_array.sv
// four way banks plus the victim tree; gives hit data and the victim line of the addressed set
`timescale 1ns/10ps

module dcache_array (
  input  logic                               clock,
  input  logic                               reset,
  input  dcache_pkg::sass_addr_t             addr,
  input  logic                               fill_en,
  input  dcache_pkg::cache_line_t            fill_line,
  input  logic                               use_hit_way,
  output logic                               hit,
  output logic [dcache_pkg::data_bits-1:0]   hit_data,
  output dcache_pkg::cache_line_t            victim,
  output dcache_pkg::sass_addr_t             victim_addr
);

  logic [dcache_pkg::num_way-1:0]   way_hit;
  logic [dcache_pkg::num_way-1:0]   way_wr;
  logic [dcache_pkg::num_way-1:0]   victim_way;
  logic [dcache_pkg::data_bits-1:0] way_data [dcache_pkg::num_way];
  dcache_pkg::cache_line_t          way_line [dcache_pkg::num_way];

  // store hits rewrite in place, everything else goes to the victim way
  assign way_wr = fill_en ? (use_hit_way ? way_hit : victim_way) : '0;

  for (genvar w = 0; w < dcache_pkg::num_way; w++) begin : g_way
    cache_way way_i (
      .clock       (clock),
      .reset       (reset),
      .rd_addr     (addr),
      .wr_en       (way_wr[w]),
      .wr_line     (fill_line),
      .hit         (way_hit[w]),
      .rd_data     (way_data[w]),
      .victim_line (way_line[w])
    );
  end

  // tree advances only when a new line comes in
  victim_tree tree_i (
    .clock      (clock),
    .reset      (reset),
    .set_index  (addr.set_index),
    .fill       (fill_en && !use_hit_way),
    .victim_way (victim_way)
  );

  assign hit = |way_hit;

  // both selects are one-hot
  always_comb begin
    hit_data = '0;
    victim   = '0;
    for (int w = 0; w < dcache_pkg::num_way; w++) begin
      if (way_hit[w]) begin
        hit_data = way_data[w];
      end
      if (victim_way[w]) begin
        victim = way_line[w];
      end
    end
  end

  always_comb begin
    victim_addr.tag       = victim.tag;
    victim_addr.set_index = addr.set_index;
    victim_addr.ignore    = '0;
  end

endmodule

// File: hw/victim_tree.sv
// per-set fill-order tree; names the way that the next line fill of a set replaces
`timescale 1ns/10ps

module victim_tree (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [dcache_pkg::idx_bits-1:0]     set_index,
  input  logic                                fill,
  output logic [dcache_pkg::num_way-1:0]      victim_way
);

  logic [dcache_pkg::num_idx-1:0] half;
  logic [dcache_pkg::num_idx-1:0] left;
  logic [dcache_pkg::num_idx-1:0] right;
  logic                           cur_half;
  logic                           cur_left;
  logic                           cur_right;

  assign cur_half  = half[set_index];
  assign cur_left  = left[set_index];
  assign cur_right = right[set_index];

  // half picks the pair, left/right picks the way inside it
  assign victim_way = {cur_half & cur_right,
                       cur_half & ~cur_right,
                       ~cur_half & cur_left,
                       ~cur_half & ~cur_left};

  // fills walk way0, way2, way1, way3
  always_ff @(posedge clock) begin
    if (reset) begin
      half  <= '0;
      left  <= '0;
      right <= '0;
    end else if (fill) begin
      half[set_index] <= ~cur_half;
      if (!cur_half) begin
        left[set_index] <= ~cur_left;
      end else begin
        right[set_index] <= ~cur_right;
      end
    end
  end

endmodule

// File: hw/cache_way.sv
// one way bank of the data cache; dcache_array instances four of them side by side
`timescale 1ns/10ps

module cache_way (
  input  logic                               clock,
  input  logic                               reset,
  input  dcache_pkg::sass_addr_t             rd_addr,
  input  logic                               wr_en,
  input  dcache_pkg::cache_line_t            wr_line,
  output logic                               hit,
  output logic [dcache_pkg::data_bits-1:0]   rd_data,
  output dcache_pkg::cache_line_t            victim_line
);

  dcache_pkg::cache_line_t lines [dcache_pkg::num_idx];
  dcache_pkg::cache_line_t cur_line;

  // line of the addressed set
  assign cur_line = lines[rd_addr.set_index];

  assign hit     = cur_line.valid && (cur_line.tag == rd_addr.tag);
  assign rd_data = cur_line.data;

  // whole line goes out so it can be evicted
  assign victim_line = cur_line;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::num_idx; i++) begin
        lines[i].valid <= 1'b0;
        lines[i].dirty <= 1'b0;
      end
    end else if (wr_en) begin
      lines[rd_addr.set_index] <= wr_line;
    end
  end

endmodule

// File: hw/dcache_pkg.sv
// shared widths and packed types for the data cache; referenced by scoped name from all RTL
package dcache_pkg;

  // cache geometry
  localparam int num_way   = 4;
  localparam int num_idx   = 8;
  localparam int idx_bits  = 3;
  localparam int tag_bits  = 5;
  // byte offset, never decoded
  localparam int off_bits  = 3;
  localparam int data_bits = 64;
  localparam int wb_depth  = 2;

  // processor byte address, tag and set_index together form the memory word address
  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] set_index;
    logic [off_bits-1:0] ignore;
  } sass_addr_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

  typedef struct packed {
    logic                 write;
    sass_addr_t           addr;
    logic [data_bits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                 store;
    sass_addr_t           addr;
    logic [data_bits-1:0] data;
  } cpu_req_t;

endpackage
